//--- lsu_pkg.sv
`default_nettype none

package lsu_pkg;

  //********************************************************************
  // widths
  //********************************************************************

  // data and address word
  typedef logic [31:0] word_t;

  // one enable bit per byte lane
  typedef logic [3:0] byte_en_t;

  // access size and sign field of loads and stores
  typedef logic [2:0] funct3_t;

  // 32 architectural registers
  localparam int DEFAULT_TAG_W = 5;

  //********************************************************************
  // funct3 encodings
  //********************************************************************

  // stores only use byte, half and word (sb, sh, sw)
  localparam funct3_t f3_byte   = 3'd0;
  localparam funct3_t f3_half   = 3'd1;
  localparam funct3_t f3_word   = 3'd2;
  localparam funct3_t f3_byte_u = 3'd4;
  localparam funct3_t f3_half_u = 3'd5;

  //********************************************************************
  // cache request state
  //********************************************************************

  // st_seen: response already arrived while the pipeline was stalled
  typedef enum logic {
    st_wait = 1'b0,
    st_seen = 1'b1
  } req_state_t;

endpackage

`default_nettype wire

//--- exmem_reg.sv
`timescale 1ns/1ps
`default_nettype none

module exmem_reg #(
  parameter int tag_w = lsu_pkg::DEFAULT_TAG_W
) (
  input  wire logic            clk,
  input  wire logic            rst_n,
  input  wire logic            advance,
  input  wire logic            req_valid,
  input  wire logic            req_store,
  input  wire lsu_pkg::funct3_t req_funct3,
  input  wire lsu_pkg::word_t   req_addr,
  input  wire lsu_pkg::word_t   req_wdata,
  input  wire logic [tag_w-1:0] req_tag,
  output logic                 mem_valid,
  output logic                 mem_store,
  output lsu_pkg::funct3_t     mem_funct3,
  output lsu_pkg::word_t       mem_addr,
  output lsu_pkg::word_t       mem_wdata,
  output logic [tag_w-1:0]     mem_tag
);

  // valid bit, cleared when nothing comes in on an advance
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      mem_valid <= 1'b0;
    end else if (advance) begin
      mem_valid <= req_valid;
    end
  end

  // operation payload
  // only meaningful while mem_valid is set
  always_ff @(posedge clk) begin
    if (advance && req_valid) begin
      mem_store  <= req_store;
      mem_funct3 <= req_funct3;
      mem_addr   <= req_addr;
      mem_wdata  <= req_wdata;
      mem_tag    <= req_tag;
    end
  end

endmodule

`default_nettype wire

//--- store_align.sv
`timescale 1ns/1ps
`default_nettype none

module store_align (
  input  wire lsu_pkg::funct3_t mem_funct3,
  input  wire lsu_pkg::word_t   mem_addr,
  input  wire lsu_pkg::word_t   mem_wdata,
  output lsu_pkg::word_t       dcache_address,
  output lsu_pkg::word_t       dcache_wdata,
  output lsu_pkg::byte_en_t    dcache_mbe
);

  import lsu_pkg::*;

  logic [1:0] offset;

  // the cache only sees word addresses
  assign offset         = mem_addr[1:0];
  assign dcache_address = {mem_addr[31:2], 2'b00};

  // move the low bytes of the store data up to their lane
  always_comb begin
    case (mem_funct3)
      f3_byte: begin
        dcache_wdata = mem_wdata << {offset, 3'b000};
        dcache_mbe   = 4'b0001 << offset;
      end
      f3_half: begin
        dcache_wdata = mem_wdata << {offset, 3'b000};
        dcache_mbe   = 4'b0011 << offset;
      end
      default: begin
        // sw, all four lanes
        dcache_wdata = mem_wdata;
        dcache_mbe   = 4'b1111;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- dcache_port.sv
`timescale 1ns/1ps
`default_nettype none

module dcache_port (
  input  wire logic clk,
  input  wire logic rst_n,
  input  wire logic mem_valid,
  input  wire logic mem_store,
  input  wire logic hold,
  input  wire logic dcache_resp,
  output logic      dcache_read,
  output logic      dcache_write,
  output logic      resp_now,
  output logic      advance,
  output logic      stall
);

  import lsu_pkg::*;

  req_state_t state;
  req_state_t state_next;
  logic       resp_seen;

  assign resp_seen = (state == st_seen);

  // strobes drop for good once the response was taken
  assign dcache_read  = mem_valid & ~mem_store & ~resp_seen;
  assign dcache_write = mem_valid &  mem_store & ~resp_seen;

  // response for the operation currently in ex/mem
  assign resp_now = dcache_resp & mem_valid & ~resp_seen;

  //********************************************************************
  // stall decision
  //********************************************************************

  assign stall   = hold | (mem_valid & ~dcache_resp & ~resp_seen);
  assign advance = ~stall;

  // remember a response that arrived while hold kept us in place
  always_comb begin
    state_next = state;
    if (advance) begin
      state_next = st_wait;
    end else if (resp_now) begin
      state_next = st_seen;
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= st_wait;
    end else begin
      state <= state_next;
    end
  end

endmodule

`default_nettype wire

//--- load_writeback.sv
`timescale 1ns/1ps
`default_nettype none

module load_writeback #(
  parameter int tag_w = lsu_pkg::DEFAULT_TAG_W
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  input  wire logic             advance,
  input  wire logic             resp_now,
  input  wire logic             mem_valid,
  input  wire logic             mem_store,
  input  wire lsu_pkg::funct3_t mem_funct3,
  input  wire lsu_pkg::word_t   mem_addr,
  input  wire logic [tag_w-1:0] mem_tag,
  input  wire lsu_pkg::word_t   dcache_rdata,
  output logic                  wb_valid,
  output lsu_pkg::word_t        wb_data,
  output logic [tag_w-1:0]      wb_tag
);

  import lsu_pkg::*;

  word_t rdata_q;
  word_t raw;
  word_t lane;
  word_t result;

  // rdata is only valid in the response cycle, keep a copy for hold
  always_ff @(posedge clk) begin
    if (resp_now) begin
      rdata_q <= dcache_rdata;
    end
  end

  assign raw  = resp_now ? dcache_rdata : rdata_q;
  assign lane = raw >> {mem_addr[1:0], 3'b000};

  // lane select and extension
  always_comb begin
    case (mem_funct3)
      f3_byte:   result = {{24{lane[7]}}, lane[7:0]};
      f3_byte_u: result = {24'd0, lane[7:0]};
      f3_half:   result = {{16{lane[15]}}, lane[15:0]};
      f3_half_u: result = {16'd0, lane[15:0]};
      default:   result = raw;
    endcase
  end

  //********************************************************************
  // mem/wb register
  //********************************************************************

  // single pulse per load, even if hold follows
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
    end else begin
      wb_valid <= advance & mem_valid & ~mem_store;
    end
  end

  // x0 always reads as zero
  always_ff @(posedge clk) begin
    if (advance && mem_valid && !mem_store) begin
      wb_data <= (mem_tag == '0) ? '0 : result;
      wb_tag  <= mem_tag;
    end
  end

endmodule

`default_nettype wire

//--- mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module mem_stage #(
  parameter int tag_w = lsu_pkg::DEFAULT_TAG_W
) (
  input  wire logic             clk,
  input  wire logic             rst_n,
  // request from execute
  input  wire logic             req_valid,
  input  wire logic             req_store,
  input  wire lsu_pkg::funct3_t req_funct3,
  input  wire lsu_pkg::word_t   req_addr,
  input  wire lsu_pkg::word_t   req_wdata,
  input  wire logic [tag_w-1:0] req_tag,
  output logic                  stall,
  // downstream pause
  input  wire logic             hold,
  // data cache
  output logic                  dcache_read,
  output logic                  dcache_write,
  output lsu_pkg::word_t        dcache_address,
  output lsu_pkg::word_t        dcache_wdata,
  output lsu_pkg::byte_en_t     dcache_mbe,
  input  wire lsu_pkg::word_t   dcache_rdata,
  input  wire logic             dcache_resp,
  // writeback
  output logic                  wb_valid,
  output lsu_pkg::word_t        wb_data,
  output logic [tag_w-1:0]      wb_tag
);

  import lsu_pkg::*;

  logic             advance;
  logic             resp_now;
  logic             mem_valid;
  logic             mem_store;
  funct3_t          mem_funct3;
  word_t            mem_addr;
  word_t            mem_wdata;
  logic [tag_w-1:0] mem_tag;

  //********************************************************************
  // ex/mem register
  //********************************************************************

  exmem_reg #(
    .tag_w (tag_w)
  ) u_exmem_reg (
    .clk        (clk),
    .rst_n      (rst_n),
    .advance    (advance),
    .req_valid  (req_valid),
    .req_store  (req_store),
    .req_funct3 (req_funct3),
    .req_addr   (req_addr),
    .req_wdata  (req_wdata),
    .req_tag    (req_tag),
    .mem_valid  (mem_valid),
    .mem_store  (mem_store),
    .mem_funct3 (mem_funct3),
    .mem_addr   (mem_addr),
    .mem_wdata  (mem_wdata),
    .mem_tag    (mem_tag)
  );

  //********************************************************************
  // cache request
  //********************************************************************

  store_align u_store_align (
    .mem_funct3     (mem_funct3),
    .mem_addr       (mem_addr),
    .mem_wdata      (mem_wdata),
    .dcache_address (dcache_address),
    .dcache_wdata   (dcache_wdata),
    .dcache_mbe     (dcache_mbe)
  );

  // advance drives both pipeline registers
  dcache_port u_dcache_port (
    .clk          (clk),
    .rst_n        (rst_n),
    .mem_valid    (mem_valid),
    .mem_store    (mem_store),
    .hold         (hold),
    .dcache_resp  (dcache_resp),
    .dcache_read  (dcache_read),
    .dcache_write (dcache_write),
    .resp_now     (resp_now),
    .advance      (advance),
    .stall        (stall)
  );

  //********************************************************************
  // load result and mem/wb
  //********************************************************************

  load_writeback #(
    .tag_w (tag_w)
  ) u_load_writeback (
    .clk          (clk),
    .rst_n        (rst_n),
    .advance      (advance),
    .resp_now     (resp_now),
    .mem_valid    (mem_valid),
    .mem_store    (mem_store),
    .mem_funct3   (mem_funct3),
    .mem_addr     (mem_addr),
    .mem_tag      (mem_tag),
    .dcache_rdata (dcache_rdata),
    .wb_valid     (wb_valid),
    .wb_data      (wb_data),
    .wb_tag       (wb_tag)
  );

endmodule

`default_nettype wire

//--- tb_mem_stage.sv
`timescale 1ns/1ps
`default_nettype none

module tb_mem_stage;

  import lsu_pkg::*;

  localparam int tag_w       = DEFAULT_TAG_W;
  localparam int max_cycles  = 100;

  typedef struct packed {
    logic             store;
    funct3_t          funct3;
    word_t            addr;
    word_t            wdata;
    logic [tag_w-1:0] tag;
    logic [3:0]       hold_cycles;
  } entry_t;

  logic             clk;
  logic             rst_n;
  logic             req_valid;
  logic             req_store;
  funct3_t          req_funct3;
  word_t            req_addr;
  word_t            req_wdata;
  logic [tag_w-1:0] req_tag;
  logic             stall;
  logic             hold;
  logic             dcache_read;
  logic             dcache_write;
  word_t            dcache_address;
  word_t            dcache_wdata;
  byte_en_t         dcache_mbe;
  word_t            dcache_rdata;
  logic             dcache_resp;
  logic             wb_valid;
  word_t            wb_data;
  logic [tag_w-1:0] wb_tag;

  entry_t           stim[$];
  word_t            model_mem[16];
  word_t            ref_mem[16];

  // expected cache requests, one per operation in issue order
  word_t            exp_addr[$];
  logic             exp_write[$];
  byte_en_t         exp_mbe[$];
  word_t            exp_wdata[$];
  // expected writebacks, loads only
  word_t            exp_data[$];
  logic [tag_w-1:0] exp_tag[$];

  bit               busy;
  bit               held_done;
  bit               cur_load;
  bit               wb_due;
  bit               taken;
  int               wait_cnt;
  int               resp_count;
  byte_en_t         mbe_e;
  word_t            wdata_e;

  mem_stage #(
    .tag_w (tag_w)
  ) u_mem_stage (
    .clk            (clk),
    .rst_n          (rst_n),
    .req_valid      (req_valid),
    .req_store      (req_store),
    .req_funct3     (req_funct3),
    .req_addr       (req_addr),
    .req_wdata      (req_wdata),
    .req_tag        (req_tag),
    .stall          (stall),
    .hold           (hold),
    .dcache_read    (dcache_read),
    .dcache_write   (dcache_write),
    .dcache_address (dcache_address),
    .dcache_wdata   (dcache_wdata),
    .dcache_mbe     (dcache_mbe),
    .dcache_rdata   (dcache_rdata),
    .dcache_resp    (dcache_resp),
    .wb_valid       (wb_valid),
    .wb_data        (wb_data),
    .wb_tag         (wb_tag)
  );

  always #10 clk = ~clk;

  //**********************************************************************
  // helpers
  //**********************************************************************

  task automatic check(input string name, input word_t got, input word_t exp);
    if (got !== exp) begin
      $display("Fail %s: got 0x%08h, expected 0x%08h", name, got, exp);
      $display("Simulation failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Simulation failed");
    $fatal(1, "run aborted");
  endtask

  // every word gets a value that depends on its full index
  function automatic word_t fill_word(input int idx);
    return (32'h9e3779b9 * idx) ^ 32'h5a5a5a5a ^ (idx << 8);
  endfunction

  function automatic word_t expect_load(input funct3_t f3, input word_t addr,
                                        input logic [tag_w-1:0] tag);
    word_t w;
    word_t sh;
    w  = ref_mem[addr[5:2]];
    sh = w >> (8 * addr[1:0]);
    if (tag == '0) return '0;
    case (f3)
      f3_byte:   return {{24{sh[7]}}, sh[7:0]};
      f3_byte_u: return {24'h0, sh[7:0]};
      f3_half:   return {{16{sh[15]}}, sh[15:0]};
      f3_half_u: return {16'h0, sh[15:0]};
      default:   return w;
    endcase
  endfunction

  task automatic add_entry(input logic st, input funct3_t f3, input word_t a,
                           input word_t d, input int tag, input int hc);
    entry_t e;
    e.store       = st;
    e.funct3      = f3;
    e.addr        = a;
    e.wdata       = d;
    e.tag         = tag[tag_w-1:0];
    e.hold_cycles = hc[3:0];
    stim.push_back(e);
  endtask

  // queue what the cache and writeback should see, update the reference
  task automatic record_expect(input entry_t e);
    byte_en_t mbe;
    word_t    data;
    int       off;
    off = int'(e.addr[1:0]);
    case (e.funct3)
      f3_byte: begin
        mbe  = 4'b0001 << off;
        data = e.wdata << (8 * off);
      end
      f3_half: begin
        mbe  = 4'b0011 << off;
        data = e.wdata << (8 * off);
      end
      default: begin
        mbe  = 4'b1111;
        data = e.wdata;
      end
    endcase
    exp_addr.push_back({e.addr[31:2], 2'b00});
    exp_write.push_back(e.store);
    exp_mbe.push_back(mbe);
    exp_wdata.push_back(data);
    if (e.store) begin
      for (int k = 0; k < 4; k++) begin
        if (mbe[k]) ref_mem[e.addr[5:2]][8*k +: 8] = data[8*k +: 8];
      end
    end else begin
      exp_data.push_back(expect_load(e.funct3, e.addr, e.tag));
      exp_tag.push_back(e.tag);
    end
  endtask

  task automatic apply_entry(input entry_t e, input bit last);
    int  n;
    bit  ok;
    req_valid  <= 1'b1;
    req_store  <= e.store;
    req_funct3 <= e.funct3;
    req_addr   <= e.addr;
    req_wdata  <= e.wdata;
    req_tag    <= e.tag;
    record_expect(e);
    n = 0;
    ok = 1'b0;
    while (!ok) begin
      @(negedge clk);
      ok = !stall;
      @(posedge clk);
      n++;
      if (n > max_cycles) abort_run("timed out waiting for a request to be accepted");
    end
    taken = 1'b1;
    if (e.hold_cycles != 0) begin
      req_valid <= 1'b0;
      hold      <= 1'b1;
      // hold alone keeps the stage stalled
      for (int c = 0; c < int'(e.hold_cycles); c++) begin
        @(negedge clk);
        check("stall", 32'(stall), 32'h1);
        @(posedge clk);
      end
      hold      <= 1'b0;
    end else if (last) begin
      req_valid <= 1'b0;
    end
  endtask

  //**********************************************************************
  // cache model
  //**********************************************************************

  always @(posedge clk) begin
    wb_due = 1'b0;
    if (!rst_n) begin
      busy      = 1'b0;
      held_done = 1'b0;
      wait_cnt  = 0;
    end else if (dcache_resp) begin
      // the DUT takes the response at this edge
      dcache_resp  <= 1'b0;
      dcache_rdata <= $urandom;
      resp_count++;
      wb_due    = cur_load & ~hold;
      held_done = hold;
    end else if (held_done) begin
      if (dcache_read || dcache_write) begin
        abort_run("cache strobe raised again after its response");
      end
      // completes at the first edge with hold low
      wb_due    = cur_load & ~hold;
      held_done = hold;
    end else begin
      if (!busy && (dcache_read || dcache_write)) begin
        if (exp_addr.size() == 0) abort_run("cache request with no operation pending");
        check("dcache_address[1:0]", 32'(dcache_address[1:0]), 32'h0);
        check("dcache_address", dcache_address, exp_addr.pop_front());
        check("dcache_write", 32'(dcache_write), 32'(exp_write.pop_front()));
        mbe_e   = exp_mbe.pop_front();
        wdata_e = exp_wdata.pop_front();
        if (dcache_write) begin
          check("dcache_mbe", 32'(dcache_mbe), 32'(mbe_e));
          check("dcache_wdata", dcache_wdata, wdata_e);
        end
        cur_load = dcache_read;
        busy     = 1'b1;
        wait_cnt = int'($urandom % 4);
      end else if (busy && !(dcache_read || dcache_write)) begin
        abort_run("cache strobe dropped before the response");
      end
      if (busy) begin
        if (wait_cnt == 0) begin
          busy = 1'b0;
          dcache_resp <= 1'b1;
          if (dcache_write) begin
            for (int k = 0; k < 4; k++) begin
              if (dcache_mbe[k]) begin
                model_mem[dcache_address[5:2]][8*k +: 8] = dcache_wdata[8*k +: 8];
              end
            end
          end else begin
            dcache_rdata <= model_mem[dcache_address[5:2]];
          end
        end else begin
          wait_cnt--;
        end
      end
    end
  end

  // writeback monitor, one expected entry per pulse
  // and a strobe in the cycle after each acceptance
  always @(negedge clk) begin
    if (rst_n) begin
      check("wb_valid", 32'(wb_valid), 32'(wb_due));
      if (taken) begin
        check("dcache_read | dcache_write", 32'(dcache_read | dcache_write), 32'h1);
        taken = 1'b0;
      end
      if (wb_valid) begin
        if (exp_tag.size() == 0) abort_run("wb_valid pulsed with no load outstanding");
        check("wb_data", wb_data, exp_data.pop_front());
        check("wb_tag", 32'(wb_tag), 32'(exp_tag.pop_front()));
      end
    end
  end

  //**********************************************************************
  // stimulus
  //**********************************************************************

  initial begin
    int seed_out;
    int n;
    clk          = 1'b0;
    rst_n        = 1'b0;
    req_valid    = 1'b0;
    req_store    = 1'b0;
    req_funct3   = '0;
    req_addr     = '0;
    req_wdata    = '0;
    req_tag      = '0;
    hold         = 1'b0;
    dcache_rdata = '0;
    dcache_resp  = 1'b0;
    resp_count   = 0;
    seed_out     = $urandom(32'hb00c5548);
    for (int i = 0; i < 16; i++) begin
      model_mem[i] = fill_word(i);
      ref_mem[i]   = fill_word(i);
    end

    // store, funct3, address, data, tag, hold cycles
    add_entry(1, f3_word,   32'h10, 32'h8badf00d, 0, 0);
    add_entry(0, f3_word,   32'h10, 32'h0,        1, 0);
    add_entry(1, f3_byte,   32'h20, 32'h55aa66f1, 0, 0);
    add_entry(1, f3_byte,   32'h21, 32'h11223382, 0, 0);
    add_entry(1, f3_byte,   32'h22, 32'hffeedd7c, 0, 0);
    add_entry(1, f3_byte,   32'h23, 32'h0badc0a3, 0, 0);
    add_entry(0, f3_word,   32'h20, 32'h0,        2, 0);
    add_entry(1, f3_half,   32'h24, 32'h12349abc, 0, 0);
    add_entry(1, f3_half,   32'h29, 32'h77778001, 0, 0);
    add_entry(1, f3_half,   32'h2e, 32'h0000fe12, 0, 0);
    add_entry(0, f3_word,   32'h24, 32'h0,        3, 0);
    add_entry(0, f3_word,   32'h28, 32'h0,        4, 0);
    add_entry(0, f3_word,   32'h2c, 32'h0,        5, 0);
    // sign and zero extension at every legal offset
    add_entry(0, f3_byte,   32'h20, 32'h0,        6, 0);
    add_entry(0, f3_byte,   32'h21, 32'h0,        7, 0);
    add_entry(0, f3_byte,   32'h22, 32'h0,        8, 0);
    add_entry(0, f3_byte,   32'h23, 32'h0,        9, 0);
    add_entry(0, f3_byte_u, 32'h20, 32'h0,       10, 0);
    add_entry(0, f3_byte_u, 32'h21, 32'h0,       11, 0);
    add_entry(0, f3_byte_u, 32'h22, 32'h0,       12, 0);
    add_entry(0, f3_byte_u, 32'h23, 32'h0,       13, 0);
    add_entry(0, f3_half,   32'h20, 32'h0,       14, 0);
    add_entry(0, f3_half,   32'h21, 32'h0,       15, 0);
    add_entry(0, f3_half,   32'h22, 32'h0,       16, 0);
    add_entry(0, f3_half_u, 32'h20, 32'h0,       17, 0);
    add_entry(0, f3_half_u, 32'h21, 32'h0,       18, 0);
    add_entry(0, f3_half_u, 32'h22, 32'h0,       19, 0);
    // x0 destination
    add_entry(0, f3_word,   32'h10, 32'h0,        0, 0);
    // hold across the response
    add_entry(0, f3_word,   32'h20, 32'h0,       20, 8);
    add_entry(1, f3_word,   32'h30, 32'hc001d00d, 0, 8);
    add_entry(0, f3_byte,   32'h33, 32'h0,       21, 8);
    add_entry(0, f3_half_u, 32'h31, 32'h0,       22, 0);
    add_entry(0, f3_word,   32'h3c, 32'h0,       23, 0);

    repeat (5) @(posedge clk);
    rst_n <= 1'b1;
    @(negedge clk);
    check("stall", 32'(stall), 32'h0);
    check("dcache_read", 32'(dcache_read), 32'h0);
    check("dcache_write", 32'(dcache_write), 32'h0);
    check("wb_valid", 32'(wb_valid), 32'h0);
    @(posedge clk);

    for (int i = 0; i < stim.size(); i++) begin
      apply_entry(stim[i], i == stim.size() - 1);
    end

    // let the last operations drain
    n = 0;
    while (exp_tag.size() != 0 || exp_addr.size() != 0 || busy) begin
      @(negedge clk);
      n++;
      if (n > max_cycles) abort_run("timed out waiting for the last operations to finish");
    end
    @(negedge clk);
    check("stall", 32'(stall), 32'h0);
    check("dcache_read", 32'(dcache_read), 32'h0);
    check("dcache_write", 32'(dcache_write), 32'h0);
    check("wb_valid", 32'(wb_valid), 32'h0);
    check("response count", 32'(resp_count), 32'(stim.size()));
    $display("Simulation completed successfully");
    $finish;
  end

endmodule

`default_nettype wire

//--- filelist.f
lsu_pkg.sv
exmem_reg.sv
store_align.sv
dcache_port.sv
load_writeback.sv
mem_stage.sv
tb_mem_stage.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the mem stage testbench with Verilator
set -e

cd "$(dirname "$0")"

LOG=sim.log

rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --timescale 1ns/1ps \
  --top-module tb_mem_stage \
  -f filelist.f \
  -o sim_mem_stage

./obj_dir/sim_mem_stage 2>&1 | tee "$LOG"

if grep -q "Simulation completed successfully" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
